// ==== core_fetch.f ====
source/core_pkg.sv
source/axi_fetch_if.sv
source/fetch_ctrl.sv
source/instr_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/core_fetch.sv
verif/axi_mem_model.sv
verif/tb_core_fetch.sv

// ==== Makefile ====
# Verilator flow for the core_fetch testbench
VERILATOR ?= verilator
TOP       ?= tb_core_fetch
RTL_TOP   ?= core_fetch
FILELIST  ?= core_fetch.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_core_fetch.sv ====
`timescale 1ns/1ps

module tb_core_fetch;
    import core_pkg::*;

    localparam int n_instr     = 2000;
    localparam int idle_limit  = 200;   // cycles without a retire
    localparam int first_limit = 50;

    logic            clock;
    logic            reset;
    logic            run_i;
    logic            ar_valid;
    axi_ar_t         ar;
    logic            ar_ready;
    logic            r_valid;
    axi_r_t          r;
    logic            r_ready;
    logic            retire_valid;
    retire_t         retire;
    logic            ar_fire;

    logic [63:0]     regs [32];        // reference register file
    logic [63:0]     model_pc;
    logic [63:0]     next_line;
    int              retired;
    int              ar_count;
    int              fwd_pairs;
    longint          cycle;
    longint          last_cycle;
    logic [4:0]      last_rd;
    logic            last_we;
    logic [63:0]     last_pc;
    logic            ar_valid_prev;
    logic            run_prev;
    logic            r_awaited;        // AR taken, beat still due
    integer          seed;

    core_fetch i_core_fetch (
        .clock          (clock),
        .reset          (reset),
        .run_i          (run_i),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_o       (ar),
        .axi_ar_ready_i (ar_ready),
        .axi_r_valid_i  (r_valid),
        .axi_r_i        (r),
        .axi_r_ready_o  (r_ready),
        .retire_valid_o (retire_valid),
        .retire_o       (retire)
    );

    axi_mem_model i_axi_mem_model (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready),
        .ar_fire_o  (ar_fire)
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string why);
        $display("%0t %s", $time, why);
        $display("Test failed");
        $fatal(1);
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // every AR is the next line in order with fixed attributes
    always @(posedge clock) begin
        if (reset) begin
            check("axi_r_ready", 64'(r_ready), 64'(r_awaited));   // only while a beat is due
        end
        if (reset && ar_fire) begin
            check("axi_ar.addr", ar.addr, next_line);
            check("axi_ar.len", 64'(ar.len), 64'd0);
            check("axi_ar.size", 64'(ar.size), 64'd3);
            check("axi_ar.burst", 64'(ar.burst), 64'd1);
            check("axi_ar.id", 64'(ar.id), 64'd0);
            check("axi_ar.prot", 64'(ar.prot), 64'd0);
            next_line = next_line + 8;
            ar_count++;
            r_awaited = 1'b1;
        end
        if (reset && r_valid && r_ready) begin
            r_awaited = 1'b0;                  // single beat, line done
        end
        if (reset) begin
            check("ar_valid_rise_while_halted", 64'(ar_valid && !ar_valid_prev && !run_prev), 0);
        end
        ar_valid_prev = ar_valid;
        run_prev      = run_i;
    end

    always @(posedge clock) begin : retire_monitor
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] val;
        logic        legal;
        logic        we;
        if (reset && retire_valid) begin
            w     = i_axi_mem_model.mem[(model_pc >> 2) % 4096];
            rd    = w[11:7];
            rs1   = w[19:15];
            rs2   = w[24:20];
            a     = regs[rs1];
            b     = regs[rs2];
            imm   = {{52{w[31]}}, w[31:20]};
            val   = '0;
            legal = 1'b1;
            case (w[6:0])
                7'b0110011: begin
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        10'b0000000_001: val = a << b[5:0];
                        10'b0000000_101: val = a >> b[5:0];
                        default:         legal = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    case (w[14:12])
                        3'b000:  val = a + imm;
                        3'b111:  val = a & imm;
                        3'b110:  val = a | imm;
                        3'b100:  val = a ^ imm;
                        default: legal = 1'b0;
                    endcase
                end
                default: legal = 1'b0;
            endcase
            we = legal && (rd != 5'd0);   // x0 and illegal never write
            check("retire.pc", retire.pc, model_pc);
            check("retire.rd", 64'(retire.rd), 64'(rd));
            check("retire.illegal", 64'(retire.illegal), 64'(!legal));
            check("retire.write_en", 64'(retire.write_en), 64'(we));
            if (legal) begin
                check("retire.value", retire.value, val);
            end
            // back-to-back dependency within one line
            if (legal && last_we && cycle == last_cycle + 1 && (last_pc >> 3) == (model_pc >> 3)
                && (rs1 == last_rd || (w[6:0] == 7'b0110011 && rs2 == last_rd))) begin
                fwd_pairs++;
            end
            if (we) begin
                regs[rd] = val;
            end
            last_cycle = cycle;
            last_rd    = rd;
            last_we    = we;
            last_pc    = model_pc;
            model_pc   = model_pc + 4;
            retired++;
        end
        cycle++;
    end

    initial begin : stimulus
        int idle;
        int prev_retired;
        int halt_left;
        int waited;
        seed          = 32'he5cdc962;
        reset         = 1'b0;
        run_i         = 1'b0;
        model_pc      = reset_pc;
        next_line     = reset_pc;
        retired       = 0;
        ar_count      = 0;
        fwd_pairs     = 0;
        cycle         = 0;
        last_cycle    = -10;
        last_rd       = '0;
        last_we       = 1'b0;
        last_pc       = '1;
        ar_valid_prev = 1'b0;
        run_prev      = 1'b0;
        r_awaited     = 1'b0;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        run_i = 1'b1;
        waited = 0;
        while (!ar_valid) begin            // first line request
            @(negedge clock);
            waited++;
            if (waited > first_limit) begin
                give_up("no AR request after reset");
            end
        end
        idle         = 0;
        prev_retired = 0;
        halt_left    = 0;
        while (retired < n_instr) begin
            @(negedge clock);
            if (retired != prev_retired) begin
                idle = 0;
            end else begin
                idle++;
            end
            prev_retired = retired;
            if (idle > idle_limit) begin
                give_up("retire stalled, no instruction retired in time");
            end
            if (halt_left > 0) begin
                halt_left--;
                run_i = (halt_left == 0);
            end else if (($unsigned($random(seed)) % 32) == 0) begin
                halt_left = 1 + $unsigned($random(seed)) % 16;
                run_i     = 1'b0;
            end
        end
        check("forwarded_pairs_seen", 64'(fwd_pairs != 0), 64'd1);
        check("ar_count_enough", 64'(ar_count >= n_instr / 2), 64'd1);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic              clock,
    input  logic              reset,
    input  logic              ar_valid_i,
    input  core_pkg::axi_ar_t ar_i,
    output logic              ar_ready_o,
    output logic              r_valid_o,
    output core_pkg::axi_r_t  r_o,
    input  logic              r_ready_i,
    output logic              ar_fire_o     // handshake lands on the next rising edge
);
    import core_pkg::*;

    localparam int depth = 4096;            // 32-bit words, 2048 lines

    logic [31:0]           mem [depth];
    integer                seed = 32'he5cdc962;
    logic                  ar_ready = 1'b0;
    logic                  r_valid = 1'b0;
    axi_r_t                r_beat = '0;
    logic                  ar_fire = 1'b0;
    logic                  pending = 1'b0;  // AR taken, beat not yet sent
    logic [addr_width-1:0] pend_addr = '0;
    int                    ar_delay = 0;
    int                    r_delay = 0;

    assign ar_ready_o = ar_ready;
    assign r_valid_o  = r_valid;
    assign r_o        = r_beat;
    assign ar_fire_o  = ar_fire;

    // program: x1..x31 seeded by addi, then random ops with many back-to-back deps
    initial begin : fill_program
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [2:0]  f3_tab [4];
        logic [9:0]  rr_tab [7];
        int          sel;
        f3_tab = '{3'b000, 3'b111, 3'b110, 3'b100};
        rr_tab = '{{7'h00, 3'b000}, {7'h20, 3'b000}, {7'h00, 3'b111}, {7'h00, 3'b110},
                   {7'h00, 3'b100}, {7'h00, 3'b001}, {7'h00, 3'b101}};
        prev_rd = 5'd0;
        for (int k = 0; k < depth; k++) begin
            r = $random(seed);
            s = $random(seed);
            if (k < 32) begin
                mem[k] = {s[11:0], 5'd0, 3'b000, 5'(k), 7'b0010011};   // x0 gets one too
            end else begin
                rd  = r[4:0];
                rs1 = r[5] ? prev_rd : r[10:6];
                rs2 = r[26] ? prev_rd : r[15:11];
                sel = int'(r[19:16]);
                if (sel == 0) begin                      // about one in sixteen
                    if (r[25]) begin
                        mem[k] = {s[31:7], 7'b0000011};  // load opcode
                    end else begin
                        mem[k] = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};  // mul
                    end
                end else if (sel <= 8) begin
                    mem[k] = {rr_tab[r[22:20] % 7][9:3], rs2, rs1,
                              rr_tab[r[22:20] % 7][2:0], rd, 7'b0110011};
                end else begin
                    mem[k] = {s[11:0], rs1, f3_tab[r[24:23]], rd, 7'b0010011};
                end
                prev_rd = rd;
            end
        end
        ar_delay = $unsigned($random(seed)) % 4;
    end

    always @(negedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready = 1'b0;
            r_valid  = 1'b0;
            ar_fire  = 1'b0;
            pending  = 1'b0;
        end else begin
            ar_fire = 1'b0;
            // address channel
            if (ar_ready) begin
                ar_ready = 1'b0;                 // taken on the last rising edge
            end else if (ar_valid_i && !pending) begin
                if (ar_delay == 0) begin
                    ar_ready  = 1'b1;
                    ar_fire   = 1'b1;
                    pending   = 1'b1;
                    pend_addr = ar_i.addr;
                    r_delay   = $unsigned($random(seed)) % 4;
                    ar_delay  = $unsigned($random(seed)) % 4;
                end else begin
                    ar_delay--;
                end
            end
            // data channel, beat only while the master waits for it
            if (r_valid) begin
                r_valid = 1'b0;
                pending = 1'b0;
            end else if (pending && r_ready_i) begin
                if (r_delay == 0) begin
                    r_valid        = 1'b1;
                    r_beat         = '0;
                    r_beat.last    = 1'b1;
                    r_beat.data    = {mem[((pend_addr >> 2) | 1) % depth],
                                      mem[((pend_addr >> 2) & ~64'd1) % depth]};
                end else begin
                    r_delay--;
                end
            end
        end
    end

endmodule

// ==== source/core_fetch.sv ====
`timescale 1ns/1ps

module core_fetch (
    input  logic              clock,
    input  logic              reset,
    input  logic              run_i,
    // AXI read master
    output logic              axi_ar_valid_o,
    output core_pkg::axi_ar_t axi_ar_o,
    input  logic              axi_ar_ready_i,
    input  logic              axi_r_valid_i,
    input  core_pkg::axi_r_t  axi_r_i,
    output logic              axi_r_ready_o,
    // retire report
    output logic              retire_valid_o,
    output core_pkg::retire_t retire_o
);
    import core_pkg::*;

    logic                  rw_valid;
    logic                  rw_ready;
    logic [addr_width-1:0] rw_addr;
    logic [xlen-1:0]       line_data;
    logic                  fetch_valid;
    fetch_pkt_t            fetch_pkt;
    logic [reg_idx_w-1:0]  rs1_idx;
    logic [reg_idx_w-1:0]  rs2_idx;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic                  op_valid;
    exec_op_t              exec_op;
    logic                  res_valid;
    retire_t               res;
    logic                  wb_valid;
    retire_t               wb;

    fetch_ctrl i_fetch_ctrl (
        .clock         (clock),
        .reset         (reset),
        .run_i         (run_i),
        .rw_valid_o    (rw_valid),
        .rw_addr_o     (rw_addr),
        .rw_ready_i    (rw_ready),
        .data_read_i   (line_data),
        .fetch_valid_o (fetch_valid),
        .fetch_o       (fetch_pkt)
    );

    axi_fetch_if i_axi_fetch_if (
        .clock          (clock),
        .reset          (reset),
        .rw_valid_i     (rw_valid),
        .rw_addr_i      (rw_addr),
        .rw_ready_o     (rw_ready),
        .data_read_o    (line_data),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_o       (axi_ar_o),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_i        (axi_r_i),
        .axi_r_ready_o  (axi_r_ready_o)
    );

    instr_decode i_instr_decode (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid_i (fetch_valid),
        .fetch_i       (fetch_pkt),
        .rf_rs1_o      (rs1_idx),
        .rf_rs2_o      (rs2_idx),
        .rf_rs1_val_i  (rs1_val),
        .rf_rs2_val_i  (rs2_val),
        .op_valid_o    (op_valid),
        .op_o          (exec_op)
    );

    alu_execute i_alu_execute (
        .clock       (clock),
        .reset       (reset),
        .op_valid_i  (op_valid),
        .op_i        (exec_op),
        .wb_valid_i  (wb_valid),
        .wb_i        (wb),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    result_writeback i_result_writeback (
        .clock          (clock),
        .reset          (reset),
        .res_valid_i    (res_valid),
        .res_i          (res),
        .rf_rs1_i       (rs1_idx),
        .rf_rs2_i       (rs2_idx),
        .rf_rs1_val_o   (rs1_val),
        .rf_rs2_val_o   (rs2_val),
        .wb_valid_o     (wb_valid),
        .wb_o           (wb),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

// ==== source/result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           res_valid_i,
    input  core_pkg::retire_t              res_i,
    // read port for decode
    input  logic [core_pkg::reg_idx_w-1:0] rf_rs1_i,
    input  logic [core_pkg::reg_idx_w-1:0] rf_rs2_i,
    output logic [core_pkg::xlen-1:0]      rf_rs1_val_o,
    output logic [core_pkg::xlen-1:0]      rf_rs2_val_o,
    // forwarding source and retire report, same entry
    output logic                           wb_valid_o,
    output core_pkg::retire_t              wb_o,
    output logic                           retire_valid_o,
    output core_pkg::retire_t              retire_o
);
    import core_pkg::*;

    logic [xlen-1:0] rf_q [reg_count];   // x0 slot never written
    logic            wr_en;
    logic            ret_valid_q;
    retire_t         ret_q;

    assign wr_en = res_valid_i && res_i.write_en && (res_i.rd != '0);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            rf_q[res_i.rd] <= res_i.value;
        end
    end

    assign rf_rs1_val_o = (rf_rs1_i == '0) ? '0 : rf_q[rf_rs1_i];
    assign rf_rs2_val_o = (rf_rs2_i == '0) ? '0 : rf_q[rf_rs2_i];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= res_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (res_valid_i) begin
            ret_q          <= res_i;
            ret_q.write_en <= wr_en;   // reports the write actually done
        end
    end

    assign wb_valid_o     = ret_valid_q;
    assign wb_o           = ret_q;
    assign retire_valid_o = ret_valid_q;
    assign retire_o       = ret_q;

    // a result aimed at x0 retires with no write
    assert property (@(posedge clock) disable iff (!reset)
        res_valid_i && (res_i.rd == '0) |=> retire_valid_o && !retire_o.write_en)
        else $error("x0 reported as written");

endmodule

// ==== source/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic               clock,
    input  logic               reset,
    input  logic               op_valid_i,
    input  core_pkg::exec_op_t op_i,
    // writeback entry for forwarding
    input  logic               wb_valid_i,
    input  core_pkg::retire_t  wb_i,
    output logic               res_valid_o,
    output core_pkg::retire_t  res_o
);
    import core_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;

    // producer writes the register this operand reads
    function automatic logic fwd_hit(input logic vld, input retire_t prod,
                                     input logic [reg_idx_w-1:0] rs);
        return vld && prod.write_en && (prod.rd != '0) && (prod.rd == rs);
    endfunction

    // newest producer first
    assign src_a = fwd_hit(res_valid_o, res_o, op_i.rs1) ? res_o.value :
                   fwd_hit(wb_valid_i, wb_i, op_i.rs1)   ? wb_i.value  : op_i.rs1_val;
    assign src_b = fwd_hit(res_valid_o, res_o, op_i.rs2) ? res_o.value :
                   fwd_hit(wb_valid_i, wb_i, op_i.rs2)   ? wb_i.value  : op_i.rs2_val;
    assign op_b  = op_i.use_imm ? op_i.imm : src_b;

    always_comb begin
        case (op_i.alu_op)
            alu_add: result = src_a + op_b;
            alu_sub: result = src_a - op_b;
            alu_and: result = src_a & op_b;
            alu_or:  result = src_a | op_b;
            alu_xor: result = src_a ^ op_b;
            alu_sll: result = src_a << op_b[5:0];   // rv64 shamt
            alu_srl: result = src_a >> op_b[5:0];
            default: result = src_a + op_b;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= op_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (op_valid_i) begin
            res_o.pc       <= op_i.pc;
            res_o.rd       <= op_i.rd;
            res_o.value    <= result;
            res_o.write_en <= op_i.write_en;
            res_o.illegal  <= op_i.illegal;
        end
    end

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           fetch_valid_i,
    input  core_pkg::fetch_pkt_t           fetch_i,
    // register file read port
    output logic [core_pkg::reg_idx_w-1:0] rf_rs1_o,
    output logic [core_pkg::reg_idx_w-1:0] rf_rs2_o,
    input  logic [core_pkg::xlen-1:0]      rf_rs1_val_i,
    input  logic [core_pkg::xlen-1:0]      rf_rs2_val_i,
    // to execute
    output logic                           op_valid_o,
    output core_pkg::exec_op_t             op_o
);
    import core_pkg::*;

    instr_u   instr;
    exec_op_t op_d;
    logic     legal;

    assign instr    = fetch_i.instr;
    assign rf_rs1_o = instr.r.rs1;   // same bit slots in both formats
    assign rf_rs2_o = instr.r.rs2;   // don't care for i-type

    always_comb begin
        op_d         = '0;
        op_d.pc      = fetch_i.pc;
        op_d.rd      = instr.r.rd;
        op_d.rs1     = instr.r.rs1;
        op_d.rs2     = instr.r.rs2;
        op_d.rs1_val = rf_rs1_val_i;
        op_d.rs2_val = rf_rs2_val_i;
        op_d.imm     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
        op_d.alu_op  = alu_add;
        legal        = 1'b1;
        case (instr.r.opcode)
            opc_op: begin
                case ({instr.r.funct7, instr.r.funct3})
                    {7'b0000000, 3'b000}: op_d.alu_op = alu_add;
                    {7'b0100000, 3'b000}: op_d.alu_op = alu_sub;
                    {7'b0000000, 3'b111}: op_d.alu_op = alu_and;
                    {7'b0000000, 3'b110}: op_d.alu_op = alu_or;
                    {7'b0000000, 3'b100}: op_d.alu_op = alu_xor;
                    {7'b0000000, 3'b001}: op_d.alu_op = alu_sll;
                    {7'b0000000, 3'b101}: op_d.alu_op = alu_srl;
                    default:              legal = 1'b0;
                endcase
            end
            opc_op_imm: begin
                op_d.use_imm = 1'b1;
                case (instr.i.funct3)
                    3'b000:  op_d.alu_op = alu_add;   // addi
                    3'b111:  op_d.alu_op = alu_and;   // andi
                    3'b110:  op_d.alu_op = alu_or;    // ori
                    3'b100:  op_d.alu_op = alu_xor;   // xori
                    default: legal = 1'b0;            // shifts by imm not supported
                endcase
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        op_d.write_en = legal;   // illegal retires without a write
        op_d.illegal  = !legal;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid_i) begin
            op_o <= op_d;
        end
    end

endmodule

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            run_i,
    // request to the read interface
    output logic                            rw_valid_o,
    output logic [core_pkg::addr_width-1:0] rw_addr_o,
    input  logic                            rw_ready_i,
    input  logic [core_pkg::xlen-1:0]       data_read_i,
    // to decode
    output logic                            fetch_valid_o,
    output core_pkg::fetch_pkt_t            fetch_o
);
    import core_pkg::*;

    logic [addr_width-1:0] pc_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc_q <= reset_pc;
        end else if (rw_ready_i) begin
            pc_q <= pc_q + addr_width'(4);    // no branches, always sequential
        end
    end

    assign rw_valid_o    = run_i;                          // no new request while halted
    assign rw_addr_o     = {pc_q[addr_width-1:3], 3'b000}; // line address
    assign fetch_valid_o = rw_ready_i;                     // one instruction per ready

    always_comb begin
        fetch_o.pc    = pc_q;
        // pc bit 2 picks the half of the line
        fetch_o.instr = pc_q[2] ? data_read_i[63:32] : data_read_i[31:0];
    end

    // pc always on a word boundary
    assert property (@(posedge clock) disable iff (!reset)
        pc_q[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

// ==== source/axi_fetch_if.sv ====
`timescale 1ns/1ps

module axi_fetch_if (
    input  logic                            clock,
    input  logic                            reset,
    // fetch side
    input  logic                            rw_valid_i,
    input  logic [core_pkg::addr_width-1:0] rw_addr_i,   // 8-byte aligned
    output logic                            rw_ready_o,
    output logic [core_pkg::xlen-1:0]       data_read_o,
    // read address channel
    output logic                            axi_ar_valid_o,
    output core_pkg::axi_ar_t               axi_ar_o,
    input  logic                            axi_ar_ready_i,
    // read data channel
    input  logic                            axi_r_valid_i,
    input  core_pkg::axi_r_t                axi_r_i,
    output logic                            axi_r_ready_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        st_idle     = 2'b00,
        st_ar_wait  = 2'b01,
        st_r_wait   = 2'b11,
        st_trans_ok = 2'b10
    } rd_state_e;

    rd_state_e             state_q;
    rd_state_e             state_d;
    logic [addr_width-1:0] addr_q;     // address of the held line
    logic [xlen-1:0]       line_q;     // held line
    logic                  addr_hit;

    assign addr_hit = (rw_addr_i == addr_q);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (rw_valid_i) begin
                    state_d = st_ar_wait;
                end
            end
            st_ar_wait: begin
                if (axi_ar_ready_i) begin      // request accepted
                    state_d = st_r_wait;
                end
            end
            st_r_wait: begin
                if (axi_r_valid_i && axi_r_i.last) begin
                    state_d = st_trans_ok;
                end
            end
            st_trans_ok: begin
                // line stays put while run is off, refetch only on a new line
                if (rw_valid_i && !addr_hit) begin
                    state_d = st_ar_wait;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // address at the AR handshake, data on the last beat
    always_ff @(posedge clock) begin
        if (state_q == st_ar_wait && axi_ar_ready_i) begin
            addr_q <= rw_addr_i;
        end
        if (state_q == st_r_wait && axi_r_valid_i && axi_r_i.last) begin
            line_q <= axi_r_i.data;
        end
    end

    assign rw_ready_o     = (state_q == st_trans_ok) && rw_valid_i && addr_hit;
    assign data_read_o    = line_q;
    assign axi_ar_valid_o = (state_q == st_ar_wait);
    assign axi_r_ready_o  = (state_q == st_r_wait);   // one beat awaited

    always_comb begin
        axi_ar_o       = '0;             // id zero
        axi_ar_o.addr  = rw_addr_i;      // pc does not move until the line is back
        axi_ar_o.len   = 8'd0;           // single beat
        axi_ar_o.size  = axi_size_8b;
        axi_ar_o.burst = axi_burst_incr;
        axi_ar_o.prot  = axi_prot_data;
    end

    // request held steady until the slave takes it
    assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_o))
        else $error("ar request changed before handshake");

    // a beat only comes back for an accepted request
    assert property (@(posedge clock) disable iff (!reset)
        axi_r_valid_i |-> state_q == st_r_wait)
        else $error("r_valid outside r_wait");

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int xlen       = 64;            // data path width
    localparam int addr_width = 64;
    localparam int id_width   = 4;
    localparam int reg_count  = 32;
    localparam int reg_idx_w  = $clog2(reg_count);
    localparam logic [addr_width-1:0] reset_pc = '0;

    // fixed read attributes of every fetch
    localparam logic [2:0] axi_size_8b    = 3'b011;   // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [2:0] axi_prot_data  = 3'b000;   // unprivileged, secure, data

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6
    } alu_op_e;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,   // register-register
        opc_op_imm = 7'b0010011    // register-immediate
    } opcode_e;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [id_width-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic [2:0]            prot;
    } axi_ar_t;

    typedef struct packed {
        logic [xlen-1:0]     data;
        logic [1:0]          resp;
        logic                last;
        logic [id_width-1:0] id;
    } axi_r_t;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        logic [6:0]           opcode;
    } i_type_t;

    // one instruction word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        instr_u                instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        alu_op_e               alu_op;
        logic [reg_idx_w-1:0]  rd;
        logic [reg_idx_w-1:0]  rs1;
        logic [reg_idx_w-1:0]  rs2;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;      // already sign extended
        logic                  use_imm;
        logic                  write_en;
        logic                  illegal;
    } exec_op_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        logic [reg_idx_w-1:0]  rd;
        logic [xlen-1:0]       value;
        logic                  write_en;
        logic                  illegal;
    } retire_t;

endpackage
